// ==== compile.f ====
design/rdp_pkg.sv
design/rdp_csr_decode.sv
design/rdp_latency_fifo.sv
design/rdp_oct_control.sv
design/rdp_rdata_result.sv
design/rdp_read_datapath.sv
test/rdp_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the read datapath testbench with Verilator.
# Pass or fail is decided from the simulation log.
set -e

cd "$(dirname "$0")"

LOG=sim.log
OBJ_DIR=obj_dir

rm -rf "$OBJ_DIR" "$LOG"

verilator --binary --timing --assert \
	-f compile.f \
	--top-module rdp_tb \
	-Mdir "$OBJ_DIR" \
	-o rdp_sim

"./$OBJ_DIR/rdp_sim" 2>&1 | tee "$LOG"

if grep -q "^TEST PASS$" "$LOG"; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see $LOG"
	exit 1
fi

// ==== test/rdp_tb.sv ====
module rdp_tb;

	import rdp_pkg::*;

	// **************************************************
	// Run length and stimulus constants
	// **************************************************
	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 2;
	localparam int RAND_CYCLES  = 130;
	localparam int OCT_CYCLES   = 200;
	localparam int DATA_CYCLES  = 100;
	// An enable needs at most L+2 edges to come out as valid
	localparam int DRAIN_CYCLES = MAX_READ_LATENCY + 2;
	localparam logic [31:0] LFSR_SEED = 32'h9287_e40b;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
	// Rough length of all tests together, APB transfers take three cycles at most
	localparam int EST_CYCLES = RESET_CYCLES + 6 * 3
		+ 3 * (3 + RAND_CYCLES + 1 + DRAIN_CYCLES)
		+ 3 * (3 + 2 + DRAIN_CYCLES + 2 + DRAIN_CYCLES)
		+ OCT_CYCLES + OCT_OFF_DELAY + 3 + DATA_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * EST_CYCLES;

	logic       pll_afi_clk;
	logic       reset_n_afi_clk;
	logic       psel;
	logic       penable;
	logic       pwrite;
	apb_addr_t  paddr;
	apb_data_t  pwdata;
	apb_data_t  prdata;
	logic       pready;
	logic       pslverr;
	afi_phase_t afi_rdata_en;
	afi_phase_t afi_rdata_en_full;
	afi_data_t  ddio_phy_dq;
	afi_data_t  afi_rdata;
	afi_phase_t afi_rdata_valid;
	afi_data_t  phy_mux_read_fifo_q;
	logic       force_oct_off;

	// Reference state, built from the register map and the timing rules
	lat_shift_t    en_hist;
	oct_shift_t    full_hist;
	read_latency_t ref_lat;
	logic          exp_sel;
	logic          exp_valid;
	logic          exp_oct_off;

	logic [31:0] lfsr_state;
	int          err_cnt   = 0;
	int          test_cnt  = 0;
	int          cycle_cnt = 0;

	rdp_read_datapath u_dut (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.psel_i                (psel),
		.penable_i             (penable),
		.pwrite_i              (pwrite),
		.paddr_i               (paddr),
		.pwdata_i              (pwdata),
		.prdata_o              (prdata),
		.pready_o              (pready),
		.pslverr_o             (pslverr),
		.afi_rdata_en_i        (afi_rdata_en),
		.afi_rdata_en_full_i   (afi_rdata_en_full),
		.ddio_phy_dq_i         (ddio_phy_dq),
		.afi_rdata_o           (afi_rdata),
		.afi_rdata_valid_o     (afi_rdata_valid),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q),
		.force_oct_off_o       (force_oct_off)
	);

	always #(CLK_PERIOD / 2) pll_afi_clk = ~pll_afi_clk;

	// Galois LFSR, one step per random bit
	function automatic logic next_random_bit();
		logic lsb;
		lsb = lfsr_state[0];
		lfsr_state = (lfsr_state >> 1) ^ (lsb ? LFSR_TAPS : 32'h0);
		return lsb;
	endfunction

	function automatic afi_data_t random_word();
		afi_data_t w;
		w = '0;
		for (int i = 0; i < AFI_DATA_WIDTH; i++)
			w[i] = next_random_bit();
		return w;
	endfunction

	// AFI byte b carries slot b/2 of group b%2, which sits in group-ordered byte g*4+t
	function automatic afi_data_t slot_order(input afi_data_t dq);
		afi_data_t res;
		int        grp;
		int        slot;
		res = '0;
		for (int b = 0; b < AFI_DATA_WIDTH / DQ_GROUP_WIDTH; b++)
		begin
			slot = b / DQS_GROUPS;
			grp  = b % DQS_GROUPS;
			res[b*8 +: 8] = dq[(grp * TIME_SLOTS + slot) * 8 +: 8];
		end
		return res;
	endfunction

	// The latency register reads back zero-extended, anything else reads zero
	function automatic apb_data_t expected_prdata(input apb_addr_t addr, input read_latency_t lat);
		if (addr == REG_LATENCY_ADDR)
			return {{(APB_DATA_WIDTH - LAT_WIDTH){1'b0}}, lat};
		return '0;
	endfunction

	task automatic log_mismatch(input string msg);
		err_cnt++;
		$display("FAIL %0t: %s", $time, msg);
	endtask

	// **************************************************
	// Reference model
	// **************************************************

	// en_hist bit k is the enable sampled k edges back, the two stages after it
	// stand for the selector and the AFI valid register
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			en_hist     <= '0;
			full_hist   <= '0;
			ref_lat     <= '0;
			exp_sel     <= 1'b0;
			exp_valid   <= 1'b0;
			exp_oct_off <= 1'b0;
		end
		else
		begin
			en_hist     <= {en_hist[MAX_READ_LATENCY-2:0], afi_rdata_en[0]};
			exp_sel     <= en_hist[ref_lat];
			exp_valid   <= exp_sel;
			full_hist   <= {full_hist[OCT_OFF_DELAY-2:0], afi_rdata_en_full[0]};
			// Termination is off only when no read came in the last six edges
			exp_oct_off <= ~(|full_hist);
			if (psel && penable && pwrite && paddr == REG_LATENCY_ADDR)
				ref_lat <= pwdata[LAT_WIDTH-1:0];
		end
	end

	// **************************************************
	// Checks
	// **************************************************
	a_apb_ready: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(psel && penable) |-> pready)
	else log_mismatch("pready low in an access cycle");

	a_apb_slverr: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(psel && penable) |-> (pslverr == (paddr != REG_LATENCY_ADDR)))
	else log_mismatch($sformatf("pslverr %b at address %h", $sampled(pslverr), $sampled(paddr)));

	a_apb_rdata: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(psel && penable && !pwrite) |-> (prdata == expected_prdata(paddr, ref_lat)))
	else log_mismatch($sformatf("prdata %h, expected %h", $sampled(prdata),
		expected_prdata($sampled(paddr), $sampled(ref_lat))));

	a_rdata_valid: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_valid == {AFI_RATE_RATIO{exp_valid}})
	else log_mismatch($sformatf("afi_rdata_valid %b, expected %b", $sampled(afi_rdata_valid),
		{AFI_RATE_RATIO{$sampled(exp_valid)}}));

	a_oct_window: assert property (@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		force_oct_off == exp_oct_off)
	else log_mismatch($sformatf("force_oct_off %b, expected %b", $sampled(force_oct_off),
		$sampled(exp_oct_off)));

	// The data path has no registers, so both buses are checked on every edge
	a_afi_order: assert property (@(posedge pll_afi_clk)
		afi_rdata == slot_order(ddio_phy_dq))
	else log_mismatch($sformatf("afi_rdata %h for capture %h", $sampled(afi_rdata),
		$sampled(ddio_phy_dq)));

	a_fifo_q_copy: assert property (@(posedge pll_afi_clk)
		phy_mux_read_fifo_q == ddio_phy_dq)
	else log_mismatch($sformatf("phy_mux_read_fifo_q %h, expected %h",
		$sampled(phy_mux_read_fifo_q), $sampled(ddio_phy_dq)));

	a_reset_values: assert property (@(posedge pll_afi_clk)
		!reset_n_afi_clk |-> (afi_rdata_valid == '0 && !force_oct_off))
	else log_mismatch("valid or force_oct_off not zero during reset");

	always @(posedge pll_afi_clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	// **************************************************
	// Stimulus tasks
	// **************************************************

	// Setup cycle, then access cycles until the slave is ready
	task automatic apb_transfer(input logic wr, input apb_addr_t addr, input apb_data_t data);
		@(posedge pll_afi_clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge pll_afi_clk);
		penable <= 1'b1;
		do
			@(posedge pll_afi_clk);
		while (!pready);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		apb_transfer(1'b1, addr, data);
	endtask

	task automatic apb_read(input apb_addr_t addr);
		apb_transfer(1'b0, addr, '0);
	endtask

	task automatic report_test(input string name, input int errs_before);
		test_cnt++;
		$display("Test %0d (%s) finished with %0d errors", test_cnt, name, err_cnt - errs_before);
	endtask

	task automatic wait_for_valid(input int limit);
		int waited;
		waited = 0;
		@(negedge pll_afi_clk);
		while (!afi_rdata_valid[0] && waited < limit)
		begin
			@(negedge pll_afi_clk);
			waited++;
		end
		if (!afi_rdata_valid[0])
		begin
			err_cnt++;
			$display("No read valid arrived within %0d cycles of the read", limit);
		end
	endtask

	task automatic register_access();
		int start;
		start = err_cnt;
		// Reset value first, then a write with the upper bits set
		apb_read(REG_LATENCY_ADDR);
		apb_write(REG_LATENCY_ADDR, 32'hffff_fff5);
		apb_read(REG_LATENCY_ADDR);
		// Address 0x04 is outside the map
		apb_write(8'h04, 32'h0000_001f);
		apb_read(8'h04);
		apb_read(REG_LATENCY_ADDR);
		report_test("register access", start);
	endtask

	task automatic valid_latency(input int lat);
		int   start;
		logic b0;
		logic b1;
		start = err_cnt;
		apb_write(REG_LATENCY_ADDR, lat);
		repeat (RAND_CYCLES)
		begin
			@(posedge pll_afi_clk);
			b0 = next_random_bit();
			b1 = next_random_bit();
			afi_rdata_en <= {b1, b0};
		end
		@(posedge pll_afi_clk);
		afi_rdata_en <= '0;
		repeat (DRAIN_CYCLES) @(posedge pll_afi_clk);
		report_test($sformatf("read valid at latency %0d", lat), start);
	endtask

	// A single read issued right after a new latency is written
	task automatic read_after_write(input int lat);
		apb_write(REG_LATENCY_ADDR, lat);
		@(posedge pll_afi_clk);
		afi_rdata_en <= 2'b01;
		@(posedge pll_afi_clk);
		afi_rdata_en <= '0;
		wait_for_valid(DRAIN_CYCLES + 2);
		repeat (DRAIN_CYCLES) @(posedge pll_afi_clk);
	endtask

	task automatic latency_change();
		int start;
		start = err_cnt;
		read_after_write(3);
		read_after_write(12);
		read_after_write(1);
		report_test("latency change", start);
	endtask

	task automatic oct_window();
		int   start;
		logic b0;
		logic b1;
		logic b2;
		start = err_cnt;
		repeat (OCT_CYCLES)
		begin
			@(posedge pll_afi_clk);
			b0 = next_random_bit();
			b1 = next_random_bit();
			b2 = next_random_bit();
			// Sparse phase 0 leaves gaps long enough for the window to close
			afi_rdata_en_full <= {b2, b0 & b1};
		end
		@(posedge pll_afi_clk);
		afi_rdata_en_full <= '0;
		repeat (OCT_OFF_DELAY + 2) @(posedge pll_afi_clk);
		report_test("termination window", start);
	endtask

	task automatic data_mapping();
		int start;
		start = err_cnt;
		repeat (DATA_CYCLES)
		begin
			@(posedge pll_afi_clk);
			ddio_phy_dq <= random_word();
		end
		report_test("data mapping", start);
	endtask

	// **************************************************
	// Test sequence
	// **************************************************
	initial
	begin
		pll_afi_clk       = 1'b0;
		reset_n_afi_clk   = 1'b0;
		psel              = 1'b0;
		penable           = 1'b0;
		pwrite            = 1'b0;
		paddr             = '0;
		pwdata            = '0;
		afi_rdata_en      = '0;
		afi_rdata_en_full = '0;
		ddio_phy_dq       = '0;
		lfsr_state        = LFSR_SEED;
		repeat (RESET_CYCLES) @(posedge pll_afi_clk);
		reset_n_afi_clk <= 1'b1;
		register_access();
		valid_latency(0);
		valid_latency(7);
		valid_latency(31);
		latency_change();
		oct_window();
		data_mapping();
		$display("Summary: %0d tests run, %0d errors", test_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== design/rdp_read_datapath.sv ====
module rdp_read_datapath (
	input  logic                pll_afi_clk,
	input  logic                reset_n_afi_clk,

	// APB slave
	input  logic                psel_i,
	input  logic                penable_i,
	input  logic                pwrite_i,
	input  rdp_pkg::apb_addr_t  paddr_i,
	input  rdp_pkg::apb_data_t  pwdata_i,
	output rdp_pkg::apb_data_t  prdata_o,
	output logic                pready_o,
	output logic                pslverr_o,

	// AFI read side from the controller
	input  rdp_pkg::afi_phase_t afi_rdata_en_i,
	input  rdp_pkg::afi_phase_t afi_rdata_en_full_i,

	// Capture bus from the IO block FIFOs
	input  rdp_pkg::afi_data_t  ddio_phy_dq_i,

	// AFI read data and valid, plus the calibration copy
	output rdp_pkg::afi_data_t  afi_rdata_o,
	output rdp_pkg::afi_phase_t afi_rdata_valid_o,
	output rdp_pkg::afi_data_t  phy_mux_read_fifo_q_o,

	// Termination override to the IO block
	output logic                force_oct_off_o
);

	import rdp_pkg::*;

	// Latency setting from the register block
	read_latency_t read_latency;
	// Valid picked from the read-enable history
	logic          read_valid;

	// **************************************************
	// Decode
	// **************************************************
	rdp_csr_decode u_decode (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.psel_i          (psel_i),
		.penable_i       (penable_i),
		.pwrite_i        (pwrite_i),
		.paddr_i         (paddr_i),
		.pwdata_i        (pwdata_i),
		.prdata_o        (prdata_o),
		.pready_o        (pready_o),
		.pslverr_o       (pslverr_o),
		.read_latency_o  (read_latency)
	);

	// **************************************************
	// Execute
	// **************************************************
	rdp_latency_fifo u_latency (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_rdata_en_i  (afi_rdata_en_i),
		.read_latency_i  (read_latency),
		.read_valid_o    (read_valid)
	);

	rdp_oct_control u_oct (
		.pll_afi_clk         (pll_afi_clk),
		.reset_n_afi_clk     (reset_n_afi_clk),
		.afi_rdata_en_full_i (afi_rdata_en_full_i),
		.force_oct_off_o     (force_oct_off_o)
	);

	// **************************************************
	// Result
	// **************************************************
	rdp_rdata_result u_result (
		.pll_afi_clk           (pll_afi_clk),
		.reset_n_afi_clk       (reset_n_afi_clk),
		.read_valid_i          (read_valid),
		.ddio_phy_dq_i         (ddio_phy_dq_i),
		.afi_rdata_valid_o     (afi_rdata_valid_o),
		.afi_rdata_o           (afi_rdata_o),
		.phy_mux_read_fifo_q_o (phy_mux_read_fifo_q_o)
	);

endmodule

// ==== design/rdp_rdata_result.sv ====
module rdp_rdata_result (
	input  logic                pll_afi_clk,
	input  logic                reset_n_afi_clk,
	input  logic                read_valid_i,
	input  rdp_pkg::afi_data_t  ddio_phy_dq_i,
	output rdp_pkg::afi_phase_t afi_rdata_valid_o,
	output rdp_pkg::afi_data_t  afi_rdata_o,
	output rdp_pkg::afi_data_t  phy_mux_read_fifo_q_o
);

	import rdp_pkg::*;

	// **************************************************
	// AFI read valid
	// **************************************************

	// With a single DQS chain the selected valid drives both phases.
	// This register is the last stage of the L+2 valid latency
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			afi_rdata_valid_o <= '0;
		end
		else
		begin
			afi_rdata_valid_o <= {AFI_RATE_RATIO{read_valid_i}};
		end
	end

	// **************************************************
	// Read data reordering
	// **************************************************

	// The capture bus is ordered by group, then by slot:
	// G1_T3 .. G1_T0, G0_T3 .. G0_T0
	// The AFI bus is ordered by slot, then by group:
	// G1_T3, G0_T3 .. G1_T0, G0_T0
	always_comb
	begin
		afi_rdata_o = '0;
		for (int g = 0; g < DQS_GROUPS; g++)
		begin
			for (int t = 0; t < TIME_SLOTS; t++)
			begin
				afi_rdata_o[t*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
					ddio_phy_dq_i[g*GROUP_DATA_WIDTH + t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
			end
		end
	end

	// The sequencer wants group order back, so the AFI slots are
	// gathered per group again for calibration
	always_comb
	begin
		phy_mux_read_fifo_q_o = '0;
		for (int g = 0; g < DQS_GROUPS; g++)
		begin
			for (int t = 0; t < TIME_SLOTS; t++)
			begin
				phy_mux_read_fifo_q_o[g*GROUP_DATA_WIDTH + t*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH] =
					afi_rdata_o[t*MEM_DQ_WIDTH + g*DQ_GROUP_WIDTH +: DQ_GROUP_WIDTH];
			end
		end
	end

endmodule

// ==== design/rdp_oct_control.sv ====
module rdp_oct_control (
	input  logic                pll_afi_clk,
	input  logic                reset_n_afi_clk,
	input  rdp_pkg::afi_phase_t afi_rdata_en_full_i,
	output logic                force_oct_off_o
);

	import rdp_pkg::*;

	// **************************************************
	// Full read-enable history
	// **************************************************

	// Bit k holds the full enable sampled k+1 edges ago
	oct_shift_t rdata_en_r;

	// Current sample on bit 0 followed by the stored history
	logic [OCT_OFF_DELAY:0] rdata_en_window;

	// Phase 1 is ignored, as it is on the valid path
	assign rdata_en_window = {rdata_en_r, afi_rdata_en_full_i[0]};

	// Termination stays on while any read sits between the on and off delays.
	// Out of reset the output is low and rises once the window is empty
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			rdata_en_r      <= '0;
			force_oct_off_o <= 1'b0;
		end
		else
		begin
			rdata_en_r      <= rdata_en_window[OCT_OFF_DELAY-1:0];
			force_oct_off_o <= ~(|rdata_en_window[OCT_OFF_DELAY:OCT_ON_DELAY]);
		end
	end

	// **************************************************
	// Checks
	// **************************************************

	// A read enters the window one edge after it is sampled, so the
	// output is low from the edge after that one
	a_oct_on_after_read: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		afi_rdata_en_full_i[0] |=> ##1 !force_oct_off_o
	) else $error("force_oct_off high right after a read enable");

endmodule

// ==== design/rdp_latency_fifo.sv ====
module rdp_latency_fifo (
	input  logic                   pll_afi_clk,
	input  logic                   reset_n_afi_clk,
	input  rdp_pkg::afi_phase_t    afi_rdata_en_i,
	input  rdp_pkg::read_latency_t read_latency_i,
	output logic                   read_valid_o
);

	import rdp_pkg::*;

	// **************************************************
	// Read-enable history
	// **************************************************

	// Bit k holds the enable that was sampled k edges ago
	lat_shift_t latency_shifter;

	// History bit picked by the current latency setting
	logic sel_bit;

	// Only phase 0 carries the read request in the FIFO-in-IO mode
	// and phase 1 of the enable is not looked at
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			latency_shifter <= '0;
		end
		else
		begin
			latency_shifter <= {latency_shifter[MAX_READ_LATENCY-2:0], afi_rdata_en_i[0]};
		end
	end

	// **************************************************
	// Latency selector
	// **************************************************

	// The 5-bit latency reaches every one of the 32 taps
	assign sel_bit = latency_shifter[read_latency_i];

	// Registered select output, one cycle after the tap holds the entry.
	// A new latency takes effect on the next sample of this register
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			read_valid_o <= 1'b0;
		end
		else
		begin
			read_valid_o <= sel_bit;
		end
	end

	// **************************************************
	// Checks
	// **************************************************

	// With a fixed latency, an enable reaches the selector after L+1 edges
	// and shows on the selector output one edge later
	a_enable_to_valid: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(afi_rdata_en_i[0] && read_latency_i == '0) ##1 (read_latency_i == '0)
			|=> read_valid_o
	) else $error("read_valid missing at latency zero");

endmodule

// ==== design/rdp_csr_decode.sv ====
module rdp_csr_decode (
	input  logic                  pll_afi_clk,
	input  logic                  reset_n_afi_clk,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  rdp_pkg::apb_addr_t    paddr_i,
	input  rdp_pkg::apb_data_t    pwdata_i,
	output rdp_pkg::apb_data_t    prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	output rdp_pkg::read_latency_t read_latency_o
);

	import rdp_pkg::*;

	// **************************************************
	// Access decode
	// **************************************************

	// The access phase is the second cycle of a transfer
	logic access;
	// Only one register exists in the map
	logic addr_hit;
	logic wr_en;
	logic rd_en;

	// Latency register, reached by the sequencer over APB
	read_latency_t latency_q;

	assign access   = psel_i & penable_i;
	assign addr_hit = (paddr_i == REG_LATENCY_ADDR);
	assign wr_en    = access & pwrite_i & addr_hit;
	assign rd_en    = access & ~pwrite_i & addr_hit;

	// No wait states, every transfer completes in its first access cycle
	assign pready_o = 1'b1;

	// Any address outside the map is flagged in the access cycle
	assign pslverr_o = access & ~addr_hit;

	// **************************************************
	// Latency register
	// **************************************************

	// A write lands on the edge that closes the access cycle
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk)
	begin
		if (!reset_n_afi_clk)
		begin
			latency_q <= '0;
		end
		else if (wr_en)
		begin
			latency_q <= pwdata_i[LAT_WIDTH-1:0];
		end
	end

	assign read_latency_o = latency_q;

	// Read data, upper bits are always zero and bad addresses return zero
	always_comb
	begin
		prdata_o = '0;
		if (rd_en)
		begin
			prdata_o[LAT_WIDTH-1:0] = latency_q;
		end
	end

	// **************************************************
	// Protocol check
	// **************************************************

	// The master must never raise PENABLE outside a selected transfer
	a_penable_needs_psel: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		penable_i |-> psel_i
	) else $error("APB penable high without psel");

	// A setup cycle is always followed by its access cycle
	a_setup_then_access: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(psel_i && !penable_i) |=> (psel_i && penable_i)
	) else $error("APB setup cycle not followed by access cycle");

endmodule

// ==== design/rdp_pkg.sv ====
package rdp_pkg;

	// **************************************************
	// Interface geometry
	// **************************************************

	// Two read DQS groups of eight DQ bits each
	localparam int DQS_GROUPS       = 2;
	localparam int DQ_GROUP_WIDTH   = 8;
	localparam int MEM_DQ_WIDTH     = DQS_GROUPS * DQ_GROUP_WIDTH;

	// Half-rate AFI, so two phases and four DQ time slots per AFI cycle
	localparam int AFI_RATE_RATIO   = 2;
	localparam int TIME_SLOTS       = 2 * AFI_RATE_RATIO;
	localparam int AFI_DATA_WIDTH   = MEM_DQ_WIDTH * TIME_SLOTS;

	// One group carries all four of its time slots back to back
	localparam int GROUP_DATA_WIDTH = DQ_GROUP_WIDTH * TIME_SLOTS;

	// **************************************************
	// Read latency and termination
	// **************************************************

	// Depth of the read-enable history and width of its select
	localparam int MAX_READ_LATENCY = 32;
	localparam int LAT_WIDTH        = $clog2(MAX_READ_LATENCY);

	// Termination window in AFI cycles, derived from the memory read latency
	localparam int MEM_T_RL         = 6;
	localparam int OCT_ON_DELAY     = (MEM_T_RL > 4) ? ((MEM_T_RL - 4) / 2) : 0;
	localparam int OCT_OFF_DELAY    = (MEM_T_RL + 6) / 2;

	// **************************************************
	// Register map
	// **************************************************
	localparam int APB_ADDR_WIDTH   = 8;
	localparam int APB_DATA_WIDTH   = 32;
	localparam logic [APB_ADDR_WIDTH-1:0] REG_LATENCY_ADDR = 8'h00;

	// Vector types that carry a meaning across module boundaries
	typedef logic [AFI_DATA_WIDTH-1:0]   afi_data_t;
	typedef logic [AFI_RATE_RATIO-1:0]   afi_phase_t;
	typedef logic [LAT_WIDTH-1:0]        read_latency_t;
	typedef logic [MAX_READ_LATENCY-1:0] lat_shift_t;
	typedef logic [OCT_OFF_DELAY-1:0]    oct_shift_t;
	typedef logic [APB_ADDR_WIDTH-1:0]   apb_addr_t;
	typedef logic [APB_DATA_WIDTH-1:0]   apb_data_t;

endpackage
